//--- Makefile
VERILATOR ?= verilator
TOP       := serv_tb
FILELIST  := serv.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/serv_cfg.svh
`ifndef SERV_CFG_SVH
`define SERV_CFG_SVH

// Data and instruction width
`define SERV_XLEN 32

// Architectural register file
`define SERV_REGS 32
`define SERV_RADDR_W 5

// Bit counter width, one step per data bit
`define SERV_BIT_W 5

// Decoded instruction buffer between fetch and execute
`define SERV_IBUF_DEPTH 2

// Fill count must hold 0 up to SERV_IBUF_DEPTH
`define SERV_IBUF_CNT_W 2

// First fetch address
`define SERV_RESET_PC 32'h0000_0000

`endif

//--- logic/serv_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "serv_cfg.svh"

module serv_exec (
   input  wire                        clk,
   input  wire                        i_arst_n,
   input  wire                        i_nonempty,
   input  wire serv_pkg::decoded_t    i_instr,
   output logic                       o_pop,
   output logic [`SERV_RADDR_W-1:0]   o_rs1_addr,
   output logic [`SERV_RADDR_W-1:0]   o_rs2_addr,
   output logic [`SERV_BIT_W-1:0]     o_bit_idx,
   input  wire                        i_rs1_bit,
   input  wire                        i_rs2_bit,
   output logic                       o_rf_wen,
   output logic [`SERV_RADDR_W-1:0]   o_rf_waddr,
   output logic [`SERV_XLEN-1:0]      o_rf_wdata,
   output logic                       o_retire_valid,
   output serv_pkg::retire_t          o_retire
);
   import serv_pkg::*;

   exec_state_e              state_q;
   logic [`SERV_BIT_W-1:0]   cnt_q;
   logic                     cnt_last;
   decoded_t                 instr_q;
   logic                     carry_q;
   logic [`SERV_XLEN-1:0]    result_q;
   logic                     op_a;
   logic                     op_b;
   logic                     sum_bit;
   logic                     carry_nxt;
   logic                     rd_bit;

   assign o_pop    = (state_q == EX_IDLE) && i_nonempty;
   assign cnt_last = &cnt_q;

   // SUB is a + ~b + 1, the +1 comes from the preset carry
   assign op_a      = i_rs1_bit;
   assign op_b      = (instr_q.use_imm ? instr_q.imm[cnt_q] : i_rs2_bit)
                      ^ (instr_q.op == ALU_SUB);
   assign sum_bit   = op_a ^ op_b ^ carry_q;
   assign carry_nxt = (op_a & op_b) | (carry_q & (op_a ^ op_b));

   always_comb begin
      case (instr_q.op)
         ALU_ADD, ALU_SUB: rd_bit = sum_bit;
         ALU_AND:          rd_bit = op_a & op_b;
         ALU_OR:           rd_bit = op_a | op_b;
         ALU_XOR:          rd_bit = op_a ^ op_b;
         default:          rd_bit = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q <= EX_IDLE;
         cnt_q   <= '0;
         carry_q <= 1'b0;
      end else begin
         case (state_q)
            EX_IDLE: begin
               if (o_pop) begin
                  state_q <= EX_RUN;
                  cnt_q   <= '0;
                  carry_q <= (i_instr.op == ALU_SUB);
               end
            end
            EX_RUN: begin
               cnt_q   <= cnt_q + 1'b1;
               carry_q <= carry_nxt;
               if (cnt_last) begin
                  state_q <= EX_DONE;
               end
            end
            EX_DONE: state_q <= EX_IDLE;
            default: state_q <= EX_IDLE;
         endcase
      end
   end

   // LSB first, so after 32 shifts bit 0 sits at the bottom
   always_ff @(posedge clk) begin
      if (o_pop) begin
         instr_q <= i_instr;
      end
      if (state_q == EX_RUN) begin
         result_q <= {rd_bit, result_q[`SERV_XLEN-1:1]};
      end
   end

   assign o_rs1_addr     = instr_q.rs1_addr;
   assign o_rs2_addr     = instr_q.rs2_addr;
   assign o_bit_idx      = cnt_q;
   assign o_rf_wen       = (state_q == EX_DONE) && instr_q.rd_wen;
   assign o_rf_waddr     = instr_q.rd_addr;
   assign o_rf_wdata     = result_q;
   assign o_retire_valid = (state_q == EX_DONE);

   always_comb begin
      o_retire.pc      = instr_q.pc;
      o_retire.instr   = instr_q.instr;
      o_retire.rd_addr = instr_q.rd_addr;
      o_retire.rd_wen  = instr_q.rd_wen;
      o_retire.result  = result_q;
   end

endmodule

`default_nettype wire

//--- logic/serv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "serv_cfg.svh"

module serv_fetch (
   input  wire                          clk,
   input  wire                          i_arst_n,
   output logic [`SERV_XLEN-1:0]        o_ibus_adr,
   output logic                         o_ibus_cyc,
   input  wire  [`SERV_XLEN-1:0]        i_ibus_rdt,
   input  wire                          i_ibus_ack,
   input  wire  [`SERV_IBUF_CNT_W-1:0]  i_ibuf_count,
   output logic                         o_push,
   output serv_pkg::decoded_t           o_decoded
);
   import serv_pkg::*;

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

   logic [`SERV_XLEN-1:0]       pc_q;
   logic [6:0]                  opcode;
   logic [2:0]                  funct3;
   logic [6:0]                  funct7;
   logic                        is_op;
   logic                        is_op_imm;
   alu_op_e                     f3_op;
   alu_op_e                     op;

   assign o_ibus_adr = pc_q;
   assign o_push     = o_ibus_cyc & i_ibus_ack;

   // Request only when the buffer can take the word about to arrive
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc_q       <= `SERV_RESET_PC;
         o_ibus_cyc <= 1'b0;
      end else if (o_push) begin
         pc_q       <= pc_q + `SERV_XLEN'd4;
         o_ibus_cyc <= 1'b0;
      end else if (!o_ibus_cyc) begin
         o_ibus_cyc <= (i_ibuf_count < `SERV_IBUF_DEPTH);
      end
   end

   assign opcode    = i_ibus_rdt[6:0];
   assign funct3    = i_ibus_rdt[14:12];
   assign funct7    = i_ibus_rdt[31:25];
   assign is_op     = (opcode == OPC_OP);
   assign is_op_imm = (opcode == OPC_OP_IMM);

   // Shared by register and immediate forms
   always_comb begin
      case (funct3)
         3'b000:  f3_op = ALU_ADD;
         3'b100:  f3_op = ALU_XOR;
         3'b110:  f3_op = ALU_OR;
         3'b111:  f3_op = ALU_AND;
         default: f3_op = ALU_NOP;
      endcase
   end

   always_comb begin
      op = ALU_NOP;
      if (is_op_imm) begin
         op = f3_op;
      end else if (is_op && (funct7 == 7'b0000000)) begin
         op = f3_op;
      end else if (is_op && (funct7 == 7'b0100000) && (funct3 == 3'b000)) begin
         op = ALU_SUB;
      end
   end

   always_comb begin
      o_decoded.pc       = pc_q;
      o_decoded.instr    = i_ibus_rdt;
      o_decoded.op       = op;
      o_decoded.rs1_addr = i_ibus_rdt[19:15];
      o_decoded.rs2_addr = i_ibus_rdt[24:20];
      o_decoded.rd_addr  = i_ibus_rdt[11:7];
      o_decoded.use_imm  = is_op_imm;
      o_decoded.imm      = {{(`SERV_XLEN-12){i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};
      o_decoded.rd_wen   = (op != ALU_NOP) && (i_ibus_rdt[11:7] != '0);
   end

endmodule

`default_nettype wire

//--- logic/serv_ibuf.sv
`timescale 1ns/1ps
`default_nettype none

`include "serv_cfg.svh"

module serv_ibuf (
   input  wire                          clk,
   input  wire                          i_arst_n,
   input  wire                          i_push,
   input  wire serv_pkg::decoded_t      i_data,
   input  wire                          i_pop,
   output serv_pkg::decoded_t           o_head,
   output logic                         o_nonempty,
   output logic [`SERV_IBUF_CNT_W-1:0]  o_count
);
   import serv_pkg::*;

   localparam int PTR_W = (`SERV_IBUF_DEPTH > 1) ? $clog2(`SERV_IBUF_DEPTH) : 1;

   decoded_t          mem [`SERV_IBUF_DEPTH];
   logic [PTR_W-1:0]  wr_ptr_q;
   logic [PTR_W-1:0]  rd_ptr_q;
   logic              do_push;
   logic              do_pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(`SERV_IBUF_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign o_nonempty = (o_count != '0);
   assign do_pop     = i_pop && o_nonempty;
   // A full buffer still accepts when the head leaves in the same cycle
   assign do_push    = i_push && ((o_count != `SERV_IBUF_DEPTH) || do_pop);
   assign o_head     = mem[rd_ptr_q];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         o_count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (do_pop) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         end
         if (do_push && !do_pop) begin
            o_count <= o_count + 1'b1;
         end else if (do_pop && !do_push) begin
            o_count <= o_count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr_q] <= i_data;
      end
   end

endmodule

`default_nettype wire

//--- logic/serv_pkg.sv
`default_nettype none

`include "serv_cfg.svh"

package serv_pkg;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_NOP = 3'd5
   } alu_op_e;

   typedef enum logic [1:0] {
      EX_IDLE = 2'd0,
      EX_RUN  = 2'd1,
      EX_DONE = 2'd2
   } exec_state_e;

   typedef struct packed {
      logic [`SERV_XLEN-1:0]    pc;
      logic [`SERV_XLEN-1:0]    instr;
      alu_op_e                  op;
      logic [`SERV_RADDR_W-1:0] rs1_addr;
      logic [`SERV_RADDR_W-1:0] rs2_addr;
      logic [`SERV_RADDR_W-1:0] rd_addr;
      logic                     use_imm;
      logic [`SERV_XLEN-1:0]    imm;
      // Low for no-ops and for rd zero
      logic                     rd_wen;
   } decoded_t;

   typedef struct packed {
      logic [`SERV_XLEN-1:0]    pc;
      logic [`SERV_XLEN-1:0]    instr;
      logic [`SERV_RADDR_W-1:0] rd_addr;
      logic                     rd_wen;
      logic [`SERV_XLEN-1:0]    result;
   } retire_t;

endpackage

`default_nettype wire

//--- logic/serv_rf.sv
`timescale 1ns/1ps
`default_nettype none

`include "serv_cfg.svh"

module serv_rf (
   input  wire                        clk,
   input  wire                        i_arst_n,
   input  wire  [`SERV_RADDR_W-1:0]   i_rs1_addr,
   input  wire  [`SERV_RADDR_W-1:0]   i_rs2_addr,
   input  wire  [`SERV_BIT_W-1:0]     i_bit_idx,
   output logic                       o_rs1_bit,
   output logic                       o_rs2_bit,
   input  wire                        i_wen,
   input  wire  [`SERV_RADDR_W-1:0]   i_waddr,
   input  wire  [`SERV_XLEN-1:0]      i_wdata
);

   logic [`SERV_XLEN-1:0] regs [`SERV_REGS];

   // x0 never takes a write, so it keeps its reset value of zero
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < `SERV_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wen && (i_waddr != '0)) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   // One bit per port per cycle
   assign o_rs1_bit = regs[i_rs1_addr][i_bit_idx];
   assign o_rs2_bit = regs[i_rs2_addr][i_bit_idx];

endmodule

`default_nettype wire

//--- logic/serv_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "serv_cfg.svh"

module serv_top (
   input  wire                     clk,
   input  wire                     i_arst_n,
   output logic [`SERV_XLEN-1:0]   o_ibus_adr,
   output logic                    o_ibus_cyc,
   input  wire  [`SERV_XLEN-1:0]   i_ibus_rdt,
   input  wire                     i_ibus_ack,
   output logic                    o_retire_valid,
   output serv_pkg::retire_t       o_retire
);
   import serv_pkg::*;

   decoded_t                     fetch_decoded;
   decoded_t                     ibuf_head;
   logic                         push;
   logic                         pop;
   logic                         ibuf_nonempty;
   logic [`SERV_IBUF_CNT_W-1:0]  ibuf_count;
   logic [`SERV_RADDR_W-1:0]     rs1_addr;
   logic [`SERV_RADDR_W-1:0]     rs2_addr;
   logic [`SERV_BIT_W-1:0]       bit_idx;
   logic                         rs1_bit;
   logic                         rs2_bit;
   logic                         rf_wen;
   logic [`SERV_RADDR_W-1:0]     rf_waddr;
   logic [`SERV_XLEN-1:0]        rf_wdata;

   serv_fetch u_fetch (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .o_ibus_adr   (o_ibus_adr),
      .o_ibus_cyc   (o_ibus_cyc),
      .i_ibus_rdt   (i_ibus_rdt),
      .i_ibus_ack   (i_ibus_ack),
      .i_ibuf_count (ibuf_count),
      .o_push       (push),
      .o_decoded    (fetch_decoded)
   );

   serv_ibuf u_ibuf (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_push     (push),
      .i_data     (fetch_decoded),
      .i_pop      (pop),
      .o_head     (ibuf_head),
      .o_nonempty (ibuf_nonempty),
      .o_count    (ibuf_count)
   );

   serv_rf u_rf (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_bit_idx  (bit_idx),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit),
      .i_wen      (rf_wen),
      .i_waddr    (rf_waddr),
      .i_wdata    (rf_wdata)
   );

   serv_exec u_exec (
      .clk            (clk),
      .i_arst_n       (i_arst_n),
      .i_nonempty     (ibuf_nonempty),
      .i_instr        (ibuf_head),
      .o_pop          (pop),
      .o_rs1_addr     (rs1_addr),
      .o_rs2_addr     (rs2_addr),
      .o_bit_idx      (bit_idx),
      .i_rs1_bit      (rs1_bit),
      .i_rs2_bit      (rs2_bit),
      .o_rf_wen       (rf_wen),
      .o_rf_waddr     (rf_waddr),
      .o_rf_wdata     (rf_wdata),
      .o_retire_valid (o_retire_valid),
      .o_retire       (o_retire)
   );

endmodule

`default_nettype wire

//--- serv.f
+incdir+include
logic/serv_pkg.sv
logic/serv_fetch.sv
logic/serv_ibuf.sv
logic/serv_rf.sv
logic/serv_exec.sv
logic/serv_top.sv
testbench/serv_props.sv
testbench/serv_tb.sv

//--- testbench/serv_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "serv_cfg.svh"

module serv_props (
   input wire                          clk,
   input wire                          i_arst_n,
   input wire                          i_cyc,
   input wire [`SERV_XLEN-1:0]         i_adr,
   input wire                          i_push,
   input wire [`SERV_IBUF_CNT_W-1:0]   i_count,
   input wire                          i_pop,
   input wire                          i_retire_valid
);

   // A request holds its address until the ack
   adr_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
      (i_cyc && $past(i_cyc)) |-> $stable(i_adr))
      else $error("instruction bus address changed while cyc was high");

   no_push_full: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_push |-> (i_count < `SERV_IBUF_CNT_W'(`SERV_IBUF_DEPTH)))
      else $error("push into a full instruction buffer");

   // Pop to retire is one idle cycle plus 32 bit steps
   pop_to_retire: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_retire_valid == $past(i_pop, 33))
      else $error("retire not exactly 33 cycles after pop");

   no_cyc_in_reset: assert property (@(posedge clk)
      !i_arst_n |-> !i_cyc)
      else $error("instruction bus cyc high during reset");

endmodule

bind serv_top serv_props u_props (
   .clk            (clk),
   .i_arst_n       (i_arst_n),
   .i_cyc          (o_ibus_cyc),
   .i_adr          (o_ibus_adr),
   .i_push         (push),
   .i_count        (ibuf_count),
   .i_pop          (pop),
   .i_retire_valid (o_retire_valid)
);

`default_nettype wire

//--- testbench/serv_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "serv_cfg.svh"

module serv_tb;
   import serv_pkg::*;

   localparam int N_INSTR = 200;
   // Per instruction: pop, 32 bit steps, done, fetch latency and margin
   localparam int WATCHDOG_CYCLES = N_INSTR * (33 + 6 + 10) + 16;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

   logic                   clk;
   logic                   arst_n;
   logic [`SERV_XLEN-1:0]  ibus_adr;
   logic                   ibus_cyc;
   logic [`SERV_XLEN-1:0]  ibus_rdt;
   logic                   ibus_ack;
   logic                   retire_valid;
   retire_t                retire;

   logic [`SERV_XLEN-1:0]  prog [N_INSTR];
   logic [`SERV_XLEN-1:0]  model_regs [`SERV_REGS];
   integer                 seed = 44617;
   int                     n_retired = 0;
   int                     delay_left = -1;

   serv_top u_dut (
      .clk            (clk),
      .i_arst_n       (arst_n),
      .o_ibus_adr     (ibus_adr),
      .o_ibus_cyc     (ibus_cyc),
      .i_ibus_rdt     (ibus_rdt),
      .i_ibus_ack     (ibus_ack),
      .o_retire_valid (retire_valid),
      .o_retire       (retire)
   );

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped at first failure");
   endtask

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         stop_with_failure($sformatf("CHECK FAILED %s expected %h actual %h",
                                     name, expected, actual));
      end
   endtask

   // Registers limited to x0..x7 so results feed later instructions often
   function automatic logic [31:0] make_instr();
      logic [31:0] r;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [11:0] imm;
      r   = $random(seed);
      rd  = {2'b00, r[6:4]};
      rs1 = {2'b00, r[9:7]};
      rs2 = {2'b00, r[12:10]};
      imm = r[31:20];
      case (r[3:0])
         4'd0, 4'd10:       return {7'h00, rs2, rs1, 3'b000, rd, OPC_OP};
         4'd1, 4'd11:       return {7'h20, rs2, rs1, 3'b000, rd, OPC_OP};
         4'd2:              return {7'h00, rs2, rs1, 3'b111, rd, OPC_OP};
         4'd3:              return {7'h00, rs2, rs1, 3'b110, rd, OPC_OP};
         4'd4:              return {7'h00, rs2, rs1, 3'b100, rd, OPC_OP};
         4'd5, 4'd9, 4'd12: return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
         4'd6:              return {imm, rs1, 3'b100, rd, OPC_OP_IMM};
         4'd7:              return {imm, rs1, 3'b110, rd, OPC_OP_IMM};
         4'd8:              return {imm, rs1, 3'b111, rd, OPC_OP_IMM};
         // Unsupported: funct7 variant of XOR, SLL, LUI
         4'd13:             return {7'h20, rs2, rs1, 3'b100, rd, OPC_OP};
         4'd14:             return {7'h00, rs2, rs1, 3'b001, rd, OPC_OP};
         default:           return {r[31:12], rd, 7'b0110111};
      endcase
   endfunction

   // Expected retirement from the RV32I rules and the model registers
   function automatic retire_t expect_retire(input logic [31:0] pc, input logic [31:0] ins,
                                             output logic known);
      retire_t     r;
      logic [31:0] a;
      logic [31:0] b;
      logic        is_imm;
      is_imm   = (ins[6:0] == OPC_OP_IMM);
      a        = model_regs[ins[19:15]];
      b        = is_imm ? {{20{ins[31]}}, ins[31:20]} : model_regs[ins[24:20]];
      known    = 1'b1;
      r.result = '0;
      if (is_imm || (ins[6:0] == OPC_OP && ins[31:25] == 7'h00)) begin
         case (ins[14:12])
            3'b000:  r.result = a + b;
            3'b100:  r.result = a ^ b;
            3'b110:  r.result = a | b;
            3'b111:  r.result = a & b;
            default: known = 1'b0;
         endcase
      end else if (ins[6:0] == OPC_OP && ins[31:25] == 7'h20 && ins[14:12] == 3'b000) begin
         r.result = a - b;
      end else begin
         known = 1'b0;
      end
      r.pc      = pc;
      r.instr   = ins;
      r.rd_addr = ins[11:7];
      r.rd_wen  = known && (ins[11:7] != 5'd0);
      return r;
   endfunction

   function automatic int pick_delay(input logic [31:0] adr);
      logic [31:0] r;
      r = $random(seed);
      // A stretch of zero-delay acks keeps the buffer full
      if (adr[31:2] >= 120 && adr[31:2] < 160) begin
         return 0;
      end
      return int'(r % 6);
   endfunction

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Instruction memory, driven on the falling edge
   always @(negedge clk) begin
      ibus_ack <= 1'b0;
      if (arst_n && ibus_cyc) begin
         if (delay_left < 0) begin
            delay_left = pick_delay(ibus_adr);
         end
         if (delay_left == 0) begin
            ibus_ack   <= 1'b1;
            ibus_rdt   <= (ibus_adr[31:2] < N_INSTR) ? prog[ibus_adr[31:2]] : 32'h0000_0013;
            delay_left = -1;
         end else begin
            delay_left = delay_left - 1;
         end
      end
   end

   always @(negedge clk) begin : compare_retire
      retire_t exp_r;
      logic    known;
      string   tag;
      if (arst_n && retire_valid && n_retired < N_INSTR) begin
         exp_r = expect_retire(32'(n_retired * 4), prog[n_retired], known);
         tag   = $sformatf("instr %0d", n_retired);
         check({tag, " pc"}, exp_r.pc, retire.pc);
         check({tag, " instr"}, exp_r.instr, retire.instr);
         check({tag, " rd_addr"}, 32'(exp_r.rd_addr), 32'(retire.rd_addr));
         check({tag, " rd_wen"}, 32'(exp_r.rd_wen), 32'(retire.rd_wen));
         if (known) begin
            check({tag, " result"}, exp_r.result, retire.result);
         end
         if (exp_r.rd_wen) begin
            model_regs[exp_r.rd_addr] = exp_r.result;
         end
         n_retired = n_retired + 1;
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      stop_with_failure($sformatf("Watchdog timeout with %0d of %0d instructions retired",
                                  n_retired, N_INSTR));
   end

   initial begin
      arst_n   = 1'b0;
      ibus_ack = 1'b0;
      ibus_rdt = '0;
      for (int i = 0; i < `SERV_REGS; i++) begin
         model_regs[i] = '0;
      end
      for (int i = 0; i < N_INSTR; i++) begin
         prog[i] = make_instr();
      end
      repeat (16) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      wait (n_retired == N_INSTR);
      @(negedge clk);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire
